// File: common/red_pkg.sv
// Shared widths, vector types, operation and element width enums, request struct

`default_nettype none

package red_pkg;

    // ********************
    // Widths
    // ********************

    // Vector register width
    localparam int VLEN = 64;

    // Scalar operand width, also the widest element
    localparam int ELEN = 32;

    // Element count at the narrowest element width
    localparam int MAX_ELEMS = VLEN / 8;

    // ********************
    // Vector types
    // ********************

    typedef logic [VLEN-1:0] vreg_t;

    typedef logic [ELEN-1:0] scalar_t;

    // One bit per element index
    typedef logic [MAX_ELEMS-1:0] vmask_t;

    // Counted in elements, 0 up to MAX_ELEMS
    typedef logic [$clog2(MAX_ELEMS):0] vl_t;

    // ********************
    // Control encodings
    // ********************

    typedef enum logic [2:0] {
        RED_SUM,
        RED_AND,
        RED_OR,
        RED_XOR,
        RED_MIN,
        RED_MINU,
        RED_MAX,
        RED_MAXU
    } red_op_e;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32
    } sew_e;

    // Per-request control fields, sampled with the operands
    typedef struct packed {
        red_op_e op;
        sew_e    sew;
        vl_t     vl;
        logic    vm;    // 1 means unmasked
        vmask_t  mask;
    } red_req_t;

endpackage

`default_nettype wire

// File: hdl/red_result_sel.sv
// Result stage: width select, zero extension, result and valid registers

`default_nettype none
`timescale 1ns/1ps

module red_result_sel (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              req_valid_i,
    input  red_pkg::sew_e     sew_i,
    input  logic [7:0]        res8_i,
    input  logic [15:0]       res16_i,
    input  red_pkg::scalar_t  res32_i,
    output logic              result_valid_o,
    output red_pkg::scalar_t  result_o
);

    import red_pkg::*;

    scalar_t result_next;

    // Zero-extend the chosen width
    always_comb begin
        unique case (sew_i)
            SEW_8:   result_next = {{(ELEN-8){1'b0}}, res8_i};
            SEW_16:  result_next = {{(ELEN-16){1'b0}}, res16_i};
            default: result_next = res32_i;
        endcase
    end

    // ********************
    // Output registers
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid_o <= 1'b0;
        end else begin
            // One pulse per request
            result_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else if (req_valid_i) begin
            result_o <= result_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/vector_reduction.sv
// Vector reduction unit top level: three width trees and the result stage

`default_nettype none
`timescale 1ns/1ps

module vector_reduction (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              req_valid_i,
    input  red_pkg::red_req_t req_i,
    input  red_pkg::vreg_t    vs2_i,
    input  red_pkg::scalar_t  vs1_i,
    output logic              result_valid_o,
    output red_pkg::scalar_t  result_o
);

    import red_pkg::*;

    logic [7:0]  res8;
    logic [15:0] res16;
    scalar_t     res32;

    // ********************
    // Width trees
    // ********************

    // All three trees evaluate every request, the stage picks one
    red_tree #(
        .SEW(8)
    ) tree8_i (
        .op_i    (req_i.op),
        .vl_i    (req_i.vl),
        .vm_i    (req_i.vm),
        .mask_i  (req_i.mask),
        .vs2_i   (vs2_i),
        .seed_i  (vs1_i[7:0]),
        .result_o(res8)
    );

    red_tree #(
        .SEW(16)
    ) tree16_i (
        .op_i    (req_i.op),
        .vl_i    (req_i.vl),
        .vm_i    (req_i.vm),
        .mask_i  (req_i.mask),
        .vs2_i   (vs2_i),
        .seed_i  (vs1_i[15:0]),
        .result_o(res16)
    );

    red_tree #(
        .SEW(ELEN)
    ) tree32_i (
        .op_i    (req_i.op),
        .vl_i    (req_i.vl),
        .vm_i    (req_i.vm),
        .mask_i  (req_i.mask),
        .vs2_i   (vs2_i),
        .seed_i  (vs1_i),
        .result_o(res32)
    );

    // Registered output stage
    red_result_sel result_sel_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid_i   (req_valid_i),
        .sew_i         (req_i.sew),
        .res8_i        (res8),
        .res16_i       (res16),
        .res32_i       (res32),
        .result_valid_o(result_valid_o),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

// File: reduction/red_combine.sv
// Reduction node: one binary operation of two elements

`default_nettype none
`timescale 1ns/1ps

module red_combine #(
    parameter int SEW = 8
) (
    input  red_pkg::red_op_e op_i,
    input  logic [SEW-1:0]   a_i,
    input  logic [SEW-1:0]   b_i,
    output logic [SEW-1:0]   y_o
);

    import red_pkg::*;

    logic a_lt_b_s;
    logic a_lt_b_u;

    // Comparators shared by min and max
    assign a_lt_b_s = $signed(a_i) < $signed(b_i);
    assign a_lt_b_u = a_i < b_i;

    always_comb begin
        unique case (op_i)
            // Wraps modulo 2**SEW
            RED_SUM:  y_o = a_i + b_i;
            RED_AND:  y_o = a_i & b_i;
            RED_OR:   y_o = a_i | b_i;
            RED_XOR:  y_o = a_i ^ b_i;
            RED_MIN:  y_o = a_lt_b_s ? a_i : b_i;
            RED_MINU: y_o = a_lt_b_u ? a_i : b_i;
            RED_MAX:  y_o = a_lt_b_s ? b_i : a_i;
            RED_MAXU: y_o = a_lt_b_u ? b_i : a_i;
        endcase
    end

endmodule

`default_nettype wire

// File: reduction/red_lane_mask.sv
// Element filter: passes an active element or substitutes the operation's identity

`default_nettype none
`timescale 1ns/1ps

module red_lane_mask #(
    parameter int SEW = 8
) (
    input  red_pkg::red_op_e op_i,
    input  logic [SEW-1:0]   elem_i,
    input  logic             active_i,
    output logic [SEW-1:0]   elem_o
);

    import red_pkg::*;

    // Signed extremes at this element width
    localparam logic [SEW-1:0] SIGNED_MAX = {1'b0, {(SEW-1){1'b1}}};
    localparam logic [SEW-1:0] SIGNED_MIN = {1'b1, {(SEW-1){1'b0}}};

    logic [SEW-1:0] identity;

    // ********************
    // Identity per operation
    // ********************
    always_comb begin
        unique case (op_i)
            RED_SUM,
            RED_OR,
            RED_XOR:  identity = '0;
            RED_AND,
            RED_MINU: identity = '1;
            RED_MIN:  identity = SIGNED_MAX;
            RED_MAX:  identity = SIGNED_MIN;
            RED_MAXU: identity = '0;
        endcase
    end

    // Inactive lanes then drop out of the fold
    assign elem_o = active_i ? elem_i : identity;

endmodule

`default_nettype wire

// File: reduction/red_tree.sv
// Reduction tree for one element width: lane split, filtering, pairwise fold, seed

`default_nettype none
`timescale 1ns/1ps

module red_tree #(
    parameter int SEW = 8
) (
    input  red_pkg::red_op_e op_i,
    input  red_pkg::vl_t     vl_i,
    input  logic             vm_i,
    input  red_pkg::vmask_t  mask_i,
    input  red_pkg::vreg_t   vs2_i,
    input  logic [SEW-1:0]   seed_i,
    output logic [SEW-1:0]   result_o
);

    import red_pkg::*;

    localparam int NUM_ELEMS = VLEN / SEW;
    localparam int NUM_NODES = 2 * NUM_ELEMS - 1;

    // Heap layout: node k folds nodes 2k+1 and 2k+2,
    // leaves sit at NUM_ELEMS-1 upward, node 0 is the total
    logic [SEW-1:0] node [NUM_NODES];

    // ********************
    // Lanes
    // ********************
    for (genvar i = 0; i < NUM_ELEMS; i++) begin : g_lane
        logic active;

        // Below vector length and enabled by mask or vm
        assign active = (vl_i > vl_t'(i)) && (vm_i || mask_i[i]);

        red_lane_mask #(
            .SEW(SEW)
        ) lane_mask_i (
            .op_i    (op_i),
            .elem_i  (vs2_i[i*SEW +: SEW]),
            .active_i(active),
            .elem_o  (node[NUM_ELEMS-1+i])
        );
    end

    // ********************
    // Pairwise fold
    // ********************
    for (genvar k = 0; k < NUM_ELEMS - 1; k++) begin : g_node
        red_combine #(
            .SEW(SEW)
        ) combine_i (
            .op_i(op_i),
            .a_i (node[2*k+1]),
            .b_i (node[2*k+2]),
            .y_o (node[k])
        );
    end

    // Seed joins after the tree
    red_combine #(
        .SEW(SEW)
    ) seed_combine_i (
        .op_i(op_i),
        .a_i (seed_i),
        .b_i (node[0]),
        .y_o (result_o)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the vector reduction testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_vector_reduction \
    -f tb.f -o vred_sim &&
./obj_dir/vred_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }

// File: tb.f
+incdir+test
common/red_pkg.sv
reduction/red_combine.sv
reduction/red_lane_mask.sv
reduction/red_tree.sv
hdl/red_result_sel.sv
hdl/vector_reduction.sv
test/tb_vector_reduction.sv

// File: test/red_ref_model.svh
// Reference functions for the expected reduction result of one request
`ifndef RED_REF_MODEL_SVH
`define RED_REF_MODEL_SVH

function automatic int elem_bits(input sew_e sew);
    case (sew)
        SEW_8:   return 8;
        SEW_16:  return 16;
        default: return 32;
    endcase
endfunction

// Two's complement value of an element of the given width
function automatic longint as_signed(input logic [31:0] x, input int bits);
    longint v;
    v = longint'({32'd0, x});
    if (x[bits-1]) begin
        v = v - (longint'(1) << bits);
    end
    return v;
endfunction

function automatic logic [31:0] apply_op(input red_op_e op, input logic [31:0] a,
                                         input logic [31:0] b, input int bits);
    case (op)
        RED_SUM:  return a + b;
        RED_AND:  return a & b;
        RED_OR:   return a | b;
        RED_XOR:  return a ^ b;
        RED_MIN:  return (as_signed(a, bits) <= as_signed(b, bits)) ? a : b;
        RED_MINU: return (a <= b) ? a : b;
        RED_MAX:  return (as_signed(a, bits) >= as_signed(b, bits)) ? a : b;
        default:  return (a >= b) ? a : b;
    endcase
endfunction

// Sequential fold of the seed and every active element, zero-extended
function automatic scalar_t expected_result(input red_req_t req, input vreg_t vs2,
                                            input scalar_t vs1);
    int          bits;
    int          n;
    logic [31:0] keep;
    logic [31:0] acc;
    logic [31:0] elem;
    bits = elem_bits(req.sew);
    n = VLEN / bits;
    keep = (bits == 32) ? 32'hFFFF_FFFF : ((32'd1 << bits) - 32'd1);
    acc = vs1 & keep;
    for (int i = 0; i < n; i++) begin
        if (i < int'(req.vl) && (req.vm || req.mask[i])) begin
            elem = 32'(vs2 >> (i * bits)) & keep;
            acc = apply_op(req.op, acc, elem, bits) & keep;
        end
    end
    return acc;
endfunction

`endif

// File: test/tb_vector_reduction.sv
// Testbench for the vector reduction unit with stimulus, expected queue and checking assertions

`default_nettype none
`timescale 1ns/1ps

module tb_vector_reduction;

    import red_pkg::*;

    `include "red_ref_model.svh"

    localparam int DRAIN_LIMIT = 20;

    logic     clk = 1'b0;
    logic     reset_n;
    logic     req_valid_i;
    red_req_t req_i;
    vreg_t    vs2_i;
    scalar_t  vs1_i;
    logic     result_valid_o;
    scalar_t  result_o;

    scalar_t  exp_q[$];
    logic     sent_valid;
    logic     exp_valid = 1'b0;
    scalar_t  exp_result = '0;
    int       seed = 16;

    vector_reduction vector_reduction_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .vs2_i         (vs2_i),
        .vs1_i         (vs1_i),
        .result_valid_o(result_valid_o),
        .result_o      (result_o)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, want));
    endtask

    // ********************
    // Expected pipeline
    // ********************
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sent_valid <= 1'b0;
        end else begin
            sent_valid <= req_valid_i;
        end
    end

    // Result of the request accepted at the last rising edge
    always @(negedge clk) begin
        exp_valid = sent_valid;
        if (sent_valid) begin
            exp_result = exp_q.pop_front();
        end
    end

    reset_valid_chk: assert property (@(posedge clk) reset_n || !result_valid_o)
        else report_mismatch("result_valid_o", 32'($sampled(result_valid_o)), 32'd0);
    reset_result_chk: assert property (@(posedge clk) reset_n || result_o == '0)
        else report_mismatch("result_o", $sampled(result_o), 32'd0);
    valid_chk: assert property (@(posedge clk) !reset_n || result_valid_o == exp_valid)
        else report_mismatch("result_valid_o", 32'($sampled(result_valid_o)),
                             32'($sampled(exp_valid)));
    result_chk: assert property (@(posedge clk)
                                 !reset_n || !exp_valid || result_o == exp_result)
        else report_mismatch("result_o", $sampled(result_o), $sampled(exp_result));

    // ********************
    // Stimulus
    // ********************
    task automatic send_request(input red_op_e op, input sew_e sew, input vl_t vl,
                                input logic vm, input vmask_t mask,
                                input vreg_t vs2, input scalar_t vs1);
        red_req_t req;
        req.op = op;
        req.sew = sew;
        req.vl = vl;
        req.vm = vm;
        req.mask = mask;
        req_valid_i = 1'b1;
        req_i = req;
        vs2_i = vs2;
        vs1_i = vs1;
        exp_q.push_back(expected_result(req, vs2, vs1));
        @(negedge clk);
    endtask

    task automatic send_random();
        logic [31:0] rnd;
        sew_e        sew;
        vl_t         vl;
        rnd = $random(seed);
        sew = (rnd[4:3] == 2'd3) ? SEW_32 : sew_e'(rnd[4:3]);
        vl = (rnd[8:5] > 4'd8) ? 4'd8 : rnd[8:5];
        send_request(red_op_e'(rnd[2:0]), sew, vl, rnd[9], rnd[17:10],
                     {$random(seed), $random(seed)}, $random(seed));
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        req_valid_i = 1'b0;
        while ((exp_q.size() != 0 || sent_valid || exp_valid) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || sent_valid || exp_valid) begin
            fail_run("Timed out waiting for outstanding results");
        end
    endtask

    initial begin
        reset_n = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        vs2_i = '0;
        vs1_i = '0;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);

        // Overflowing sums back to back at every width
        for (int s = 0; s < 3; s++) begin
            send_request(RED_SUM, sew_e'(2'(s)), 4'd8, 1'b1, 8'h00,
                         64'hF0E1_D2C3_B4A5_9687, 32'hFFFF_FF80);
        end
        drain_results();

        // and, or, xor under random masks
        for (int o = 1; o < 4; o++) begin
            for (int s = 0; s < 3; s++) begin
                send_request(red_op_e'(3'(o)), sew_e'(2'(s)), 4'd8, 1'b0, 8'($random(seed)),
                             {$random(seed), $random(seed)} | 64'hF0F0_F0F0_F0F0_F0F0,
                             $random(seed));
            end
        end
        drain_results();

        // Signed and unsigned min and max on negative elements
        for (int o = 4; o < 8; o++) begin
            for (int s = 0; s < 3; s++) begin
                send_request(red_op_e'(3'(o)), sew_e'(2'(s)), 4'd8, 1'b1, 8'h00,
                             64'h80FF_7F01_C000_FFFE, 32'h0000_0005);
            end
        end
        drain_results();

        // Length edge cases
        send_request(RED_SUM, SEW_8, 4'd0, 1'b1, 8'hFF, 64'h0102_0304_0506_0708, 32'hABCD_EF12);
        send_request(RED_MAX, SEW_16, 4'd8, 1'b0, 8'h00, 64'h7FFF_7FFF_7FFF_7FFF, 32'h1234_8001);
        send_request(RED_MINU, SEW_32, 4'd8, 1'b1, 8'h00, 64'h0000_0003_0000_0007, 32'hFFFF_FFFF);
        send_request(RED_SUM, SEW_16, 4'd8, 1'b1, 8'h00, 64'h0001_0002_0003_0004, 32'h0000_0010);
        send_request(RED_XOR, SEW_8, 4'd3, 1'b1, 8'h00, 64'hFF00_FF00_0F0F_3355, 32'h0000_0000);
        drain_results();

        repeat (40) send_random();
        drain_results();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
